// ==== sblk_pkg.sv ====
// Superblock shared sizes, opcodes, instruction views and bundle types
`default_nettype none

package sblk_pkg;

   // Chain and word sizes
   localparam int N_TILE    = 4;
   localparam int WID_DATA  = 8;
   // 16-bit products, four of them, plus room to accumulate
   localparam int WID_PSUM  = 24;
   localparam int DEPTH_BUF = 16;
   localparam int WID_ADDR  = $clog2(DEPTH_BUF);
   // Counts run 1 to DEPTH_BUF
   localparam int WID_LEN   = WID_ADDR + 1;
   localparam int WID_TILE  = $clog2(N_TILE);

   // Issue to psum write: one read, one multiply, one adder per tile
   localparam int CHAIN_LAT = N_TILE + 2;
   // Readback issue to output strobe
   localparam int RD_LAT    = 2;
   localparam int WID_DRAIN = $clog2(CHAIN_LAT);

   // Buffer select inside a tile
   localparam logic TGT_WEIGHT = 1'b0;
   localparam logic TGT_ACT    = 1'b1;

   typedef logic [WID_DATA-1:0] data_t;
   typedef logic [WID_PSUM-1:0] psum_t;
   typedef logic [WID_ADDR-1:0] addr_t;
   typedef logic [WID_TILE-1:0] tile_idx_t;
   typedef logic [WID_LEN-1:0]  len_t;

   typedef enum logic [1:0] {
      OP_LOAD = 2'd0,
      OP_MAC  = 2'd1,
      OP_READ = 2'd2
   } op_e;

   // Load view of the instruction word
   typedef struct packed {
      op_e        op;
      logic       target;
      tile_idx_t  tile;
      addr_t      base;
      len_t       len;
      logic [5:0] pad;
   } inst_load_t;

   // Compute view, read uses psum_base and len only
   typedef struct packed {
      op_e   op;
      logic  accum;
      addr_t act_base;
      addr_t w_base;
      addr_t psum_base;
      len_t  len;
   } inst_mac_t;

   // One 20-bit word, op sits in the top bits of both views
   typedef union packed {
      inst_load_t load;
      inst_mac_t  mac;
   } inst_t;

   // Read request for one tile
   typedef struct packed {
      addr_t act_addr;
      addr_t w_addr;
   } tile_rd_t;

   // Broadcast buffer write from the sequencer
   typedef struct packed {
      logic      en;
      logic      target;
      tile_idx_t tile;
      addr_t     addr;
      data_t     data;
   } buf_wr_t;

endpackage

`default_nettype wire

// ==== sblk_ctrl.sv ====
// Superblock sequencer for buffer loads, dot-product issue and psum readback
`default_nettype none

module sblk_ctrl (
   input  logic               clk_h,
   input  logic               rst_n,
   input  logic               inst_en,
   input  sblk_pkg::inst_t    inst_data,
   input  sblk_pkg::data_t    act_data_in,
   input  logic               act_data_in_vld,
   output logic               act_data_in_req,
   output sblk_pkg::buf_wr_t  buf_wr,
   output logic               issue_vld,
   output sblk_pkg::tile_rd_t issue_rd,
   output sblk_pkg::addr_t    issue_psum_addr,
   output logic               issue_accum,
   output logic               rd_vld,
   output sblk_pkg::addr_t    rd_addr,
   output logic               status_sblk
);
   import sblk_pkg::*;

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_LOAD,
      ST_MAC,
      ST_READ,
      ST_DRAIN
   } state_e;

   state_e               state;
   inst_t                inst_q;
   len_t                 pos;
   len_t                 cur_len;
   addr_t                pos_addr;
   logic [WID_DRAIN-1:0] drain_cnt;
   logic                 beat;
   logic                 last_pos;

   // Length field sits in a different place in each view
   assign cur_len  = (state == ST_LOAD) ? inst_q.load.len : inst_q.mac.len;
   // A zero length ends after one position
   assign last_pos = (pos + 1'b1) >= cur_len;
   assign pos_addr = pos[WID_ADDR-1:0];

   // Word accepted only with both strobes high
   assign act_data_in_req = (state == ST_LOAD);
   assign beat            = act_data_in_req & act_data_in_vld;

   // One compute position per MAC cycle
   assign issue_vld         = (state == ST_MAC);
   assign issue_rd.act_addr = inst_q.mac.act_base + pos_addr;
   assign issue_rd.w_addr   = inst_q.mac.w_base + pos_addr;
   assign issue_psum_addr   = inst_q.mac.psum_base + pos_addr;
   assign issue_accum       = inst_q.mac.accum;

   // Readback addresses in order
   assign rd_vld  = (state == ST_READ);
   assign rd_addr = inst_q.mac.psum_base + pos_addr;

   assign status_sblk = (state != ST_IDLE);

   always_ff @(posedge clk_h or negedge rst_n) begin
      if (!rst_n) begin
         state     <= ST_IDLE;
         inst_q    <= '0;
         pos       <= '0;
         drain_cnt <= '0;
      end else begin
         case (state)
            ST_IDLE: begin
               pos <= '0;
               if (inst_en) begin
                  inst_q <= inst_data;
                  case (inst_data.load.op)
                     OP_LOAD: state <= ST_LOAD;
                     OP_MAC:  state <= ST_MAC;
                     OP_READ: state <= ST_READ;
                     default: state <= ST_IDLE;
                  endcase
               end
            end
            ST_LOAD: begin
               // Source may stall, position only moves on a beat
               if (beat) begin
                  pos <= pos + 1'b1;
                  if (last_pos) begin
                     state <= ST_IDLE;
                  end
               end
            end
            ST_MAC: begin
               pos <= pos + 1'b1;
               if (last_pos) begin
                  state     <= ST_DRAIN;
                  // Hold busy until the last position leaves the chain
                  drain_cnt <= WID_DRAIN'(CHAIN_LAT - 1);
               end
            end
            ST_READ: begin
               pos <= pos + 1'b1;
               if (last_pos) begin
                  state     <= ST_DRAIN;
                  drain_cnt <= WID_DRAIN'(RD_LAT - 1);
               end
            end
            ST_DRAIN: begin
               if (drain_cnt == '0) begin
                  state <= ST_IDLE;
               end else begin
                  drain_cnt <= drain_cnt - 1'b1;
               end
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   // Load write lands one cycle after its beat
   always_ff @(posedge clk_h or negedge rst_n) begin
      if (!rst_n) begin
         buf_wr <= '0;
      end else begin
         buf_wr.en     <= beat;
         buf_wr.target <= inst_q.load.target;
         buf_wr.tile   <= inst_q.load.tile;
         buf_wr.addr   <= inst_q.load.base + pos_addr;
         buf_wr.data   <= act_data_in;
      end
   end

   // No new instruction while a previous one is still in flight
   a_no_inst_busy : assert property (@(posedge clk_h) disable iff (!rst_n)
      status_sblk |-> !inst_en)
      else $error("sblk_ctrl: inst_en while busy");

endmodule

`default_nettype wire

// ==== sblk_skew.sv ====
// Superblock delay lines that stagger tile reads and align psum writes
`default_nettype none

module sblk_skew (
   input  logic                                      clk_h,
   input  logic                                      rst_n,
   input  logic                                      issue_vld,
   input  sblk_pkg::tile_rd_t                        issue_rd,
   input  sblk_pkg::addr_t                           issue_psum_addr,
   input  logic                                      issue_accum,
   output sblk_pkg::tile_rd_t [sblk_pkg::N_TILE-1:0] tile_rd,
   output sblk_pkg::addr_t                           acc_rd_addr,
   output logic                                      acc_en,
   output logic                                      psum_wr_en,
   output sblk_pkg::addr_t                           psum_wr_addr
);
   import sblk_pkg::*;

   tile_rd_t [N_TILE-2:0]  rd_pipe;
   logic [CHAIN_LAT-1:0]   wr_vld_pipe;
   addr_t [CHAIN_LAT-1:0]  wr_addr_pipe;

   // Tile i sees the request i cycles late, one cycle per cascade adder
   assign tile_rd = {rd_pipe, issue_rd};

   // Psum read starts with the issue, so its data meets tile 0
   assign acc_rd_addr  = issue_psum_addr;
   assign psum_wr_en   = wr_vld_pipe[CHAIN_LAT-1];
   assign psum_wr_addr = wr_addr_pipe[CHAIN_LAT-1];

   always_ff @(posedge clk_h) begin
      rd_pipe[0] <= issue_rd;
      for (int i = 1; i < N_TILE - 1; i++) begin
         rd_pipe[i] <= rd_pipe[i-1];
      end
      wr_addr_pipe <= {wr_addr_pipe[CHAIN_LAT-2:0], issue_psum_addr};
   end

   // Up to CHAIN_LAT positions in flight
   always_ff @(posedge clk_h or negedge rst_n) begin
      if (!rst_n) begin
         wr_vld_pipe <= '0;
         acc_en      <= 1'b0;
      end else begin
         wr_vld_pipe <= {wr_vld_pipe[CHAIN_LAT-2:0], issue_vld};
         acc_en      <= issue_vld & issue_accum;
      end
   end

   a_wr_en_known : assert property (@(posedge clk_h) disable iff (!rst_n)
      !$isunknown(psum_wr_en))
      else $error("sblk_skew: psum_wr_en unknown");

endmodule

`default_nettype wire

// ==== sblk_stile.sv ====
// Supertile with weight and activation buffers, multiplier and cascade adder
`default_nettype none

module sblk_stile #(
   parameter int unsigned TILE_IDX = 0
) (
   input  logic               clk_h,
   input  logic               rst_n,
   input  sblk_pkg::buf_wr_t  buf_wr,
   input  sblk_pkg::tile_rd_t tile_rd,
   input  sblk_pkg::psum_t    psum_cas_in,
   output sblk_pkg::psum_t    psum_cas_out
);
   import sblk_pkg::*;

   data_t                 w_mem [DEPTH_BUF];
   data_t                 act_mem [DEPTH_BUF];
   data_t                 w_q;
   data_t                 act_q;
   logic [2*WID_DATA-1:0] prod_q;
   logic                  wr_sel;
   logic                  w_wr;
   logic                  act_wr;

   // Broadcast write, this tile only
   assign wr_sel = buf_wr.en && (buf_wr.tile == tile_idx_t'(TILE_IDX));
   assign w_wr   = wr_sel && (buf_wr.target == TGT_WEIGHT);
   assign act_wr = wr_sel && (buf_wr.target == TGT_ACT);

   // Weight buffer, registered read
   always_ff @(posedge clk_h) begin
      if (w_wr) begin
         w_mem[buf_wr.addr] <= buf_wr.data;
      end
      w_q <= w_mem[tile_rd.w_addr];
   end

   // Activation buffer, registered read
   always_ff @(posedge clk_h) begin
      if (act_wr) begin
         act_mem[buf_wr.addr] <= buf_wr.data;
      end
      act_q <= act_mem[tile_rd.act_addr];
   end

   // Multiply stage then cascade add stage
   always_ff @(posedge clk_h or negedge rst_n) begin
      if (!rst_n) begin
         prod_q       <= '0;
         psum_cas_out <= '0;
      end else begin
         prod_q       <= act_q * w_q;
         // Upstream sum arrives one cycle later than the upstream tile's own product
         psum_cas_out <= psum_cas_in + psum_t'(prod_q);
      end
   end

endmodule

`default_nettype wire

// ==== sblk_psum_buf.sv ====
// Partial-sum buffer with accumulate read port and registered readback
`default_nettype none

module sblk_psum_buf (
   input  logic            clk_h,
   input  logic            rst_n,
   input  logic            wr_en,
   input  sblk_pkg::addr_t wr_addr,
   input  sblk_pkg::psum_t wr_data,
   input  sblk_pkg::addr_t acc_rd_addr,
   input  logic            acc_en,
   output sblk_pkg::psum_t acc_data,
   input  logic            rd_vld,
   input  sblk_pkg::addr_t rd_addr,
   output sblk_pkg::psum_t psum_rd_data,
   output logic            psum_rd_vld
);
   import sblk_pkg::*;

   psum_t mem [DEPTH_BUF];
   psum_t acc_q;
   psum_t rd_q;
   logic  rd_vld_q;

   // Cleared on reset so a first compute can accumulate onto zero
   always_ff @(posedge clk_h or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < DEPTH_BUF; i++) begin
            mem[i] <= '0;
         end
      end else if (wr_en) begin
         mem[wr_addr] <= wr_data;
      end
   end

   // Accumulate port, zero when the position does not accumulate
   always_ff @(posedge clk_h) begin
      acc_q    <= mem[acc_rd_addr];
      acc_data <= acc_en ? acc_q : '0;
   end

   // Readback: memory read register then output register
   always_ff @(posedge clk_h) begin
      rd_q         <= mem[rd_addr];
      psum_rd_data <= rd_q;
   end

   always_ff @(posedge clk_h or negedge rst_n) begin
      if (!rst_n) begin
         rd_vld_q    <= 1'b0;
         psum_rd_vld <= 1'b0;
      end else begin
         rd_vld_q    <= rd_vld;
         psum_rd_vld <= rd_vld_q;
      end
   end

   // Accumulate read must not see a same-cycle write to its address
   a_no_acc_collide : assert property (@(posedge clk_h) disable iff (!rst_n)
      acc_en |-> !($past(wr_en) && ($past(wr_addr) == $past(acc_rd_addr))))
      else $error("sblk_psum_buf: write and accumulate read collide");

endmodule

`default_nettype wire

// ==== sblk.sv ====
// Superblock top with sequencer, skew lines, supertile chain and psum buffer
`default_nettype none

module sblk (
   input  logic            clk_h,
   input  logic            rst_n,
   input  logic            inst_en,
   input  sblk_pkg::inst_t inst_data,
   input  sblk_pkg::data_t act_data_in,
   input  logic            act_data_in_vld,
   output logic            act_data_in_req,
   output sblk_pkg::psum_t psum_rd_data,
   output logic            psum_rd_vld,
   output logic            status_sblk
);
   import sblk_pkg::*;

   // Sequencer outputs
   buf_wr_t                buf_wr;
   logic                   issue_vld;
   tile_rd_t               issue_rd;
   addr_t                  issue_psum_addr;
   logic                   issue_accum;
   logic                   rd_vld;
   addr_t                  rd_addr;

   // Skewed requests and aligned write
   tile_rd_t [N_TILE-1:0]  tile_rd;
   addr_t                  acc_rd_addr;
   logic                   acc_en;
   logic                   psum_wr_en;
   addr_t                  psum_wr_addr;

   // Cascade, entry 0 is the accumulate value, last entry the dot product
   psum_t [N_TILE:0]       psum_cas;

   sblk_ctrl u_sblk_ctrl (
      .clk_h           (clk_h),
      .rst_n           (rst_n),
      .inst_en         (inst_en),
      .inst_data       (inst_data),
      .act_data_in     (act_data_in),
      .act_data_in_vld (act_data_in_vld),
      .act_data_in_req (act_data_in_req),
      .buf_wr          (buf_wr),
      .issue_vld       (issue_vld),
      .issue_rd        (issue_rd),
      .issue_psum_addr (issue_psum_addr),
      .issue_accum     (issue_accum),
      .rd_vld          (rd_vld),
      .rd_addr         (rd_addr),
      .status_sblk     (status_sblk)
   );

   sblk_skew u_sblk_skew (
      .clk_h           (clk_h),
      .rst_n           (rst_n),
      .issue_vld       (issue_vld),
      .issue_rd        (issue_rd),
      .issue_psum_addr (issue_psum_addr),
      .issue_accum     (issue_accum),
      .tile_rd         (tile_rd),
      .acc_rd_addr     (acc_rd_addr),
      .acc_en          (acc_en),
      .psum_wr_en      (psum_wr_en),
      .psum_wr_addr    (psum_wr_addr)
   );

   // Tile chain
   for (genvar ii = 0; ii < N_TILE; ii++) begin : g_tile
      sblk_stile #(.TILE_IDX(ii)) u_stile (
         .clk_h        (clk_h),
         .rst_n        (rst_n),
         .buf_wr       (buf_wr),
         .tile_rd      (tile_rd[ii]),
         .psum_cas_in  (psum_cas[ii]),
         .psum_cas_out (psum_cas[ii+1])
      );
   end

   sblk_psum_buf u_psum_buf (
      .clk_h        (clk_h),
      .rst_n        (rst_n),
      .wr_en        (psum_wr_en),
      .wr_addr      (psum_wr_addr),
      .wr_data      (psum_cas[N_TILE]),
      .acc_rd_addr  (acc_rd_addr),
      .acc_en       (acc_en),
      .acc_data     (psum_cas[0]),
      .rd_vld       (rd_vld),
      .rd_addr      (rd_addr),
      .psum_rd_data (psum_rd_data),
      .psum_rd_vld  (psum_rd_vld)
   );

endmodule

`default_nettype wire

// ==== tb_sblk.sv ====
// Superblock testbench that plays the pattern file and checks psum readback
`default_nettype none

module tb_sblk;
   timeunit 1ns;
   timeprecision 1ps;

   import sblk_pkg::*;

   localparam int RST_CYCLES = 16;

   logic   clk_h;
   logic   rst_n;
   logic   inst_en;
   inst_t  inst_data;
   data_t  act_data_in;
   logic   act_data_in_vld;
   logic   act_data_in_req;
   psum_t  psum_rd_data;
   logic   psum_rd_vld;
   logic   status_sblk;

   // Pattern records as kind letter and hex value
   logic [7:0]  rec_kind [$];
   logic [31:0] rec_val [$];
   int          rec_idx;
   data_t       load_words [DEPTH_BUF];
   psum_t       exp_vals [DEPTH_BUF];

   int     errors;
   int     checks;
   int     tests;
   int     cycle_cnt;
   int     cycle_limit;
   integer seed;

   sblk sblk_inst (
      .clk_h           (clk_h),
      .rst_n           (rst_n),
      .inst_en         (inst_en),
      .inst_data       (inst_data),
      .act_data_in     (act_data_in),
      .act_data_in_vld (act_data_in_vld),
      .act_data_in_req (act_data_in_req),
      .psum_rd_data    (psum_rd_data),
      .psum_rd_vld     (psum_rd_vld),
      .status_sblk     (status_sblk)
   );

   // 40 ns clock
   initial begin
      clk_h = 1'b0;
      forever #20 clk_h = ~clk_h;
   end

   task automatic check_psum(input psum_t expected, input psum_t actual, input string name);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("mismatch at %0t: %s expected %h, got %h", $time, name, expected, actual);
      end
   endtask

   task automatic check_status(input logic expected, input logic actual, input string name);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("mismatch at %0t: %s expected %b, got %b", $time, name, expected, actual);
      end
   endtask

   // Reads all records and sizes the cycle budget from the lengths
   task automatic read_patterns();
      int               fd;
      int               rc;
      logic [7:0]       kind;
      logic [31:0]      value;
      logic [8*128-1:0] line_buf;
      inst_t            inst;
      cycle_limit = RST_CYCLES;
      fd = $fopen("sblk_patterns.txt", "r");
      if (fd == 0) begin
         $display("cannot open sblk_patterns.txt");
         errors++;
      end else begin
         while ($fscanf(fd, " %c", kind) == 1) begin
            if (kind == "#") begin
               rc = $fgets(line_buf, fd);
            end else begin
               rc = $fscanf(fd, " %h", value);
               if (rc != 1) begin
                  $display("pattern record %0d has no value", rec_kind.size());
                  errors++;
               end
               rec_kind.push_back(kind);
               rec_val.push_back(value);
               if (kind == "I") begin
                  inst = value[$bits(inst_t)-1:0];
                  // Each position gets the chain depth plus a few cycles of slack
                  if (inst.load.op == OP_LOAD) begin
                     cycle_limit += int'(inst.load.len) * (CHAIN_LAT + 4);
                  end else begin
                     cycle_limit += int'(inst.mac.len) * (CHAIN_LAT + 4);
                  end
               end
            end
         end
         $fclose(fd);
      end
   endtask

   task automatic take_record(input logic [7:0] kind, output logic [31:0] value);
      value = '0;
      if (rec_idx < rec_kind.size() && rec_kind[rec_idx] == kind) begin
         value = rec_val[rec_idx];
         rec_idx++;
      end else begin
         $display("pattern file lacks a %c record at record %0d", kind, rec_idx);
         errors++;
      end
   endtask

   task automatic send_inst(input inst_t inst);
      @(posedge clk_h);
      inst_en   <= 1'b1;
      inst_data <= inst;
      @(posedge clk_h);
      inst_en   <= 1'b0;
   endtask

   // Called on a falling edge
   task automatic wait_idle();
      while (status_sblk) begin
         @(negedge clk_h);
      end
      check_status(1'b0, act_data_in_req, "act_data_in_req");
   endtask

   task automatic run_load(input inst_t inst, input int n, input logic gaps);
      int taken;
      taken = 0;
      send_inst(inst);
      while (taken < n) begin
         act_data_in     <= load_words[taken];
         act_data_in_vld <= gaps ? (($random(seed) & 3) != 0) : 1'b1;
         @(negedge clk_h);
         check_status(1'b1, status_sblk, "status_sblk");
         check_status(1'b1, act_data_in_req, "act_data_in_req");
         // Word counts only when both strobes are high
         if (act_data_in_vld && act_data_in_req) begin
            taken++;
         end
         @(posedge clk_h);
      end
      act_data_in_vld <= 1'b0;
      @(negedge clk_h);
      // Busy drops one cycle after the last beat
      check_status(1'b0, status_sblk, "status_sblk");
      wait_idle();
   endtask

   task automatic run_mac(input inst_t inst);
      int busy;
      int want;
      busy = 0;
      want = int'(inst.mac.len) + CHAIN_LAT;
      send_inst(inst);
      @(negedge clk_h);
      check_status(1'b1, status_sblk, "status_sblk");
      while (status_sblk) begin
         busy++;
         @(negedge clk_h);
      end
      // One issue per position and then the chain drains
      if (busy != want) begin
         errors++;
         $display("mismatch at %0t: status_sblk busy cycles expected %0d, got %0d",
                  $time, want, busy);
      end
      wait_idle();
   endtask

   task automatic run_read(input inst_t inst, input int n);
      int got;
      int cyc;
      got = 0;
      cyc = 0;
      send_inst(inst);
      @(negedge clk_h);
      check_status(1'b1, status_sblk, "status_sblk");
      while (status_sblk) begin
         cyc++;
         if (psum_rd_vld) begin
            // Buffer read and output register ahead of each entry
            if (cyc != got + RD_LAT + 1) begin
               errors++;
               $display("mismatch at %0t: psum_rd_vld cycle expected %0d, got %0d",
                        $time, got + RD_LAT + 1, cyc);
            end
            if (got < n) begin
               check_psum(exp_vals[got], psum_rd_data, "psum_rd_data");
            end
            got++;
         end
         @(negedge clk_h);
      end
      check_status(1'b0, psum_rd_vld, "psum_rd_vld");
      if (got != n) begin
         errors++;
         $display("mismatch at %0t: psum_rd_vld strobes expected %0d, got %0d",
                  $time, n, got);
      end
      wait_idle();
   endtask

   // A test closes with each read instruction
   task automatic run_records();
      int          n;
      int          j;
      int          test_err;
      logic [31:0] value;
      inst_t       cur;
      rec_idx  = 0;
      test_err = errors;
      while (rec_idx < rec_kind.size()) begin
         if (rec_kind[rec_idx] != "I") begin
            $display("pattern record %0d is not an instruction", rec_idx);
            errors++;
            rec_idx++;
         end else begin
            cur = rec_val[rec_idx][$bits(inst_t)-1:0];
            rec_idx++;
            case (cur.load.op)
               OP_LOAD: begin
                  n = int'(cur.load.len);
                  value = '0;
                  for (j = 0; j < n; j++) begin
                     // Four words per record with the first word in the low byte
                     if (j % 4 == 0) begin
                        take_record("D", value);
                     end
                     load_words[j] = value[8*(j%4) +: 8];
                  end
                  run_load(cur, n, cur.load.pad[0]);
               end
               OP_MAC: begin
                  run_mac(cur);
               end
               OP_READ: begin
                  n = int'(cur.mac.len);
                  for (j = 0; j < n; j++) begin
                     take_record("E", value);
                     exp_vals[j] = value[WID_PSUM-1:0];
                  end
                  run_read(cur, n);
                  tests++;
                  $display("test %0d %s, %0d errors", tests,
                           (errors == test_err) ? "ok" : "failed", errors - test_err);
                  test_err = errors;
               end
               default: begin
                  $display("pattern record %0d holds an unknown opcode", rec_idx - 1);
                  errors++;
               end
            endcase
         end
      end
   endtask

   initial begin : main
      rst_n           <= 1'b0;
      inst_en         <= 1'b0;
      inst_data       <= '0;
      act_data_in     <= '0;
      act_data_in_vld <= 1'b0;
      errors = 0;
      checks = 0;
      tests  = 0;
      seed   = 32'hf368;
      read_patterns();
      repeat (RST_CYCLES) @(posedge clk_h);
      rst_n <= 1'b1;
      @(negedge clk_h);
      // Idle outputs straight after reset
      check_status(1'b0, status_sblk, "status_sblk");
      check_status(1'b0, act_data_in_req, "act_data_in_req");
      check_status(1'b0, psum_rd_vld, "psum_rd_vld");
      run_records();
      $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
      if (errors == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

   // Run limit from the pattern lengths
   initial begin : watchdog
      cycle_cnt = 0;
      @(posedge clk_h);
      while (cycle_cnt < cycle_limit) begin
         @(posedge clk_h);
         cycle_cnt++;
      end
      $display("run stopped after %0d cycles without finishing", cycle_cnt);
      $display("TB FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== sblk_patterns.txt ====
# kind value: I instruction word, D four load bytes with the first in the low byte
# E expected psum readback; a load with pad bit 0 set gets random gaps on act_data_in_vld
# Reset state, psum 0 to 3 read as zero
I 80004
E 000000
E 000000
E 000000
E 000000
# Weights then activations for tiles 0 to 3 at addresses 0 to 3
I 00100
D 04030201
I 08100
D 08070605
I 10100
D 020180ff
I 18100
D 0c0b0a09
I 20100
D 40302010
I 28100
D 14131211
I 30100
D 03ff02ff
I 38100
D 01010101
# Dot product into psum 0 to 3 without accumulate
I 40004
I 80004
E 00fe6f
E 0001b6
E 00021f
E 0001b2
# Same product accumulated on top
I 60004
I 80004
E 01fcde
E 00036c
E 00043e
E 000364
# Activations again at address 8 with gaps, result into psum 4 to 7
I 24101
D 40302010
I 2c101
D 14131211
I 34101
D 03ff02ff
I 3c101
D 01010101
I 50084
I 80084
E 00fe6f
E 0001b6
E 00021f
E 0001b2

// ==== filelist.f ====
sblk_pkg.sv
sblk_ctrl.sv
sblk_skew.sv
sblk_stile.sv
sblk_psum_buf.sv
sblk.sv
tb_sblk.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the superblock testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_sblk \
   -f filelist.f -o sim_sblk || exit 1
out=$(./obj_dir/sim_sblk)
echo "$out"
echo "$out" | grep -q "TB PASSED" && echo "simulation passed" || { echo "simulation failed"; exit 1; }
